// File: common/zynq_glue_pkg.sv
`default_nettype none

package zynq_glue_pkg;

   // address and register word widths
   localparam int addr_width_lp     = 32;
   localparam int csr_data_width_lp = 32;

   typedef logic [addr_width_lp-1:0]     paddr_t;
   typedef logic [csr_data_width_lp-1:0] csr_data_t;

   // processor DRAM starts here, the host window is at most 256 MB
   localparam paddr_t bp_dram_base_lp = 32'h8000_0000;
   localparam paddr_t dram_limit_lp   = 32'h1000_0000;

   // profiler granularity is 8 MB, taken from processor address bits 29:23
   localparam int num_regions_lp  = 128;
   localparam int region_msb_lp   = 29;
   localparam int region_width_lp = 7;

   typedef logic [region_width_lp-1:0] region_idx_t;
   typedef logic [num_regions_lp-1:0]  profile_t;

   // host register map, word indices
   localparam int csr_addr_width_lp = 3;

   typedef logic [csr_addr_width_lp-1:0] csr_addr_t;

   localparam csr_addr_t csr_reset_idx_lp      = 3'd0;
   localparam csr_addr_t csr_dram_alloc_idx_lp = 3'd1;
   localparam csr_addr_t csr_dram_base_idx_lp  = 3'd2;
   // words 3 to 6 hold the profiler bitmap, low word first
   localparam csr_addr_t csr_profile_idx_lp    = 3'd3;
   localparam int        num_csr_lp            = 7;

endpackage

`default_nettype wire

// File: dram/dram_addr_xlate.sv
`default_nettype none

module dram_addr_xlate
  (input wire                            aclk
   , input wire                          rst_i

   // processor side DRAM address
   , input wire                          v_i
   , input wire zynq_glue_pkg::paddr_t   addr_i

   // base of the host allocated DRAM window
   , input wire zynq_glue_pkg::paddr_t   dram_base_i

   // ARM physical address, one cycle later
   , output logic                        v_o
   , output zynq_glue_pkg::paddr_t       addr_o
   , output zynq_glue_pkg::region_idx_t  region_o
   );

   import zynq_glue_pkg::*;

   logic        v_r;
   paddr_t      addr_r;
   region_idx_t region_r;
   paddr_t      offset;

   // strip the processor DRAM base, the xor acts as a subtract for this base
   assign offset = addr_i ^ bp_dram_base_lp;

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         v_r <= 1'b0;
      end
      else begin
         v_r <= v_i;
      end
   end

   // address and region only load on a strobe
   always_ff @(posedge aclk) begin
      if (v_i) begin
         addr_r   <= offset + dram_base_i;
         region_r <= addr_i[region_msb_lp -: region_width_lp];
      end
   end

   assign v_o      = v_r;
   assign addr_o   = addr_r;
   assign region_o = region_r;

   // processor must stay inside the window the host allocated
   dram_window_a : assert property (
      @(posedge aclk) disable iff (rst_i)
      v_i |-> (offset < dram_limit_lp)
   ) else $error("dram_addr_xlate: address %h beyond DRAM window", addr_i);

endmodule

`default_nettype wire

// File: dram/mem_profiler.sv
`default_nettype none

module mem_profiler
  (input wire                             aclk
   , input wire                           rst_i

   // processor reset also wipes the map
   , input wire                           clear_i

   , input wire                           wr_v_i
   , input wire zynq_glue_pkg::region_idx_t wr_region_i
   , input wire                           rd_v_i
   , input wire zynq_glue_pkg::region_idx_t rd_region_i

   , output zynq_glue_pkg::profile_t      profile_o
   );

   import zynq_glue_pkg::*;

   profile_t profile_r;
   profile_t wr_hit;
   profile_t rd_hit;

   // one-hot hit per channel, both may land in the same cycle
   always_comb begin
      wr_hit = '0;
      rd_hit = '0;
      if (wr_v_i) begin
         wr_hit[wr_region_i] = 1'b1;
      end
      if (rd_v_i) begin
         rd_hit[rd_region_i] = 1'b1;
      end
   end

   always_ff @(posedge aclk) begin
      if (rst_i | clear_i) begin
         profile_r <= '0;
      end
      else begin
         profile_r <= profile_r | wr_hit | rd_hit;
      end
   end

   assign profile_o = profile_r;

   // bits are sticky until the processor goes back into reset
   profile_sticky_a : assert property (
      @(posedge aclk) disable iff (rst_i)
      !clear_i |=> ((profile_r & $past(profile_r)) == $past(profile_r))
   ) else $error("mem_profiler: region bit dropped without a clear");

endmodule

`default_nettype wire

// File: verilog/host_csr_regs.sv
`default_nettype none

module host_csr_regs
  (input wire                             aclk
   , input wire                           rst_i

   // host write strobe
   , input wire                           csr_we_i
   , input wire zynq_glue_pkg::csr_addr_t csr_waddr_i
   , input wire zynq_glue_pkg::csr_data_t csr_wdata_i

   // host read strobe, answered one cycle later
   , input wire                           csr_re_i
   , input wire zynq_glue_pkg::csr_addr_t csr_raddr_i
   , output logic                         csr_rvalid_o
   , output zynq_glue_pkg::csr_data_t     csr_rdata_o

   // profiler bitmap for words 3 to 6
   , input wire zynq_glue_pkg::profile_t  profile_i

   , output logic                         bp_reset_o
   , output zynq_glue_pkg::paddr_t        dram_base_o
   );

   import zynq_glue_pkg::*;

   csr_data_t reset_word_r;
   csr_data_t dram_alloc_r;
   csr_data_t dram_base_r;
   logic      rvalid_r;
   csr_data_t rdata_r;

   csr_data_t [num_csr_lp-1:0] csr_words;

   // writable words, writes to word 3 and up are dropped
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         reset_word_r <= '0;
         dram_alloc_r <= '0;
         dram_base_r  <= '0;
      end
      else if (csr_we_i) begin
         case (csr_waddr_i)
            csr_reset_idx_lp:      reset_word_r <= csr_wdata_i;
            csr_dram_alloc_idx_lp: dram_alloc_r <= csr_wdata_i;
            csr_dram_base_idx_lp:  dram_base_r  <= csr_wdata_i;
            default: ;
         endcase
      end
   end

   // readable image of the register map
   always_comb begin
      csr_words[csr_reset_idx_lp]      = reset_word_r;
      csr_words[csr_dram_alloc_idx_lp] = dram_alloc_r;
      csr_words[csr_dram_base_idx_lp]  = dram_base_r;
      for (int i = 0; i < num_csr_lp - csr_profile_idx_lp; i++) begin
         csr_words[csr_profile_idx_lp + i] = profile_i[i*csr_data_width_lp +: csr_data_width_lp];
      end
   end

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         rvalid_r <= 1'b0;
      end
      else begin
         rvalid_r <= csr_re_i;
      end
   end

   // unmapped word 7 reads as zero
   always_ff @(posedge aclk) begin
      if (csr_re_i) begin
         if (csr_raddr_i < num_csr_lp) begin
            rdata_r <= csr_words[csr_raddr_i];
         end
         else begin
            rdata_r <= '0;
         end
      end
   end

   assign csr_rvalid_o = rvalid_r;
   assign csr_rdata_o  = rdata_r;

   // word 0 bit 0 is a low-true processor reset
   assign bp_reset_o  = rst_i | ~reset_word_r[0];
   assign dram_base_o = dram_base_r;

   // host must not read a word in the same cycle it writes it
   csr_rw_collide_a : assert property (
      @(posedge aclk) disable iff (rst_i)
      (csr_we_i && csr_re_i) |-> (csr_waddr_i != csr_raddr_i)
   ) else $error("host_csr_regs: read and write of word %0d collide", csr_raddr_i);

endmodule

`default_nettype wire

// File: verilog/zynq_dram_glue.sv
`default_nettype none

module zynq_dram_glue
  (input wire                             aclk
   , input wire                           rst_i

   // host register port
   , input wire                           csr_we_i
   , input wire zynq_glue_pkg::csr_addr_t csr_waddr_i
   , input wire zynq_glue_pkg::csr_data_t csr_wdata_i
   , input wire                           csr_re_i
   , input wire zynq_glue_pkg::csr_addr_t csr_raddr_i
   , output logic                         csr_rvalid_o
   , output zynq_glue_pkg::csr_data_t     csr_rdata_o

   // processor reset, high true
   , output logic                         bp_reset_o

   // processor DRAM address strobes
   , input wire                           dram_aw_v_i
   , input wire zynq_glue_pkg::paddr_t    dram_awaddr_i
   , input wire                           dram_ar_v_i
   , input wire zynq_glue_pkg::paddr_t    dram_araddr_i

   // translated addresses toward the ARM DRAM port
   , output logic                         m_aw_v_o
   , output zynq_glue_pkg::paddr_t        m_awaddr_o
   , output logic                         m_ar_v_o
   , output zynq_glue_pkg::paddr_t        m_araddr_o
   );

   import zynq_glue_pkg::*;

   logic        bp_reset;
   paddr_t      dram_base;
   region_idx_t aw_region;
   region_idx_t ar_region;
   profile_t    profile;

   host_csr_regs csr
     (.aclk          (aclk)
      ,.rst_i        (rst_i)
      ,.csr_we_i     (csr_we_i)
      ,.csr_waddr_i  (csr_waddr_i)
      ,.csr_wdata_i  (csr_wdata_i)
      ,.csr_re_i     (csr_re_i)
      ,.csr_raddr_i  (csr_raddr_i)
      ,.csr_rvalid_o (csr_rvalid_o)
      ,.csr_rdata_o  (csr_rdata_o)
      ,.profile_i    (profile)
      ,.bp_reset_o   (bp_reset)
      ,.dram_base_o  (dram_base)
      );

   assign bp_reset_o = bp_reset;

   // write channel
   dram_addr_xlate aw_xlate
     (.aclk         (aclk)
      ,.rst_i       (rst_i)
      ,.v_i         (dram_aw_v_i)
      ,.addr_i      (dram_awaddr_i)
      ,.dram_base_i (dram_base)
      ,.v_o         (m_aw_v_o)
      ,.addr_o      (m_awaddr_o)
      ,.region_o    (aw_region)
      );

   // read channel
   dram_addr_xlate ar_xlate
     (.aclk         (aclk)
      ,.rst_i       (rst_i)
      ,.v_i         (dram_ar_v_i)
      ,.addr_i      (dram_araddr_i)
      ,.dram_base_i (dram_base)
      ,.v_o         (m_ar_v_o)
      ,.addr_o      (m_araddr_o)
      ,.region_o    (ar_region)
      );

   // region hits follow the translator output strobes
   mem_profiler profiler
     (.aclk         (aclk)
      ,.rst_i       (rst_i)
      ,.clear_i     (bp_reset)
      ,.wr_v_i      (m_aw_v_o)
      ,.wr_region_i (aw_region)
      ,.rd_v_i      (m_ar_v_o)
      ,.rd_region_i (ar_region)
      ,.profile_o   (profile)
      );

endmodule

`default_nettype wire

// File: sim/tb_zynq_dram_glue.sv
`default_nettype none

module tb_zynq_dram_glue;

   import zynq_glue_pkg::*;

   localparam int timeout_cycles = 50;

   logic      aclk;
   logic      rst_i;
   logic      csr_we_i;
   csr_addr_t csr_waddr_i;
   csr_data_t csr_wdata_i;
   logic      csr_re_i;
   csr_addr_t csr_raddr_i;
   logic      csr_rvalid_o;
   csr_data_t csr_rdata_o;
   logic      bp_reset_o;
   logic      dram_aw_v_i;
   paddr_t    dram_awaddr_i;
   logic      dram_ar_v_i;
   paddr_t    dram_araddr_i;
   logic      m_aw_v_o;
   paddr_t    m_awaddr_o;
   logic      m_ar_v_o;
   paddr_t    m_araddr_o;

   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   string       test_name;
   logic [31:0] cyc;
   int unsigned seed_dummy;
   paddr_t      dram_base;
   profile_t    ref_profile;

   // expected translator outputs and the cycle each one is due
   paddr_t      aw_exp_q[$];
   paddr_t      ar_exp_q[$];
   logic [31:0] aw_due_q[$];
   logic [31:0] ar_due_q[$];

   zynq_dram_glue DUT
     (.aclk           (aclk)
      ,.rst_i         (rst_i)
      ,.csr_we_i      (csr_we_i)
      ,.csr_waddr_i   (csr_waddr_i)
      ,.csr_wdata_i   (csr_wdata_i)
      ,.csr_re_i      (csr_re_i)
      ,.csr_raddr_i   (csr_raddr_i)
      ,.csr_rvalid_o  (csr_rvalid_o)
      ,.csr_rdata_o   (csr_rdata_o)
      ,.bp_reset_o    (bp_reset_o)
      ,.dram_aw_v_i   (dram_aw_v_i)
      ,.dram_awaddr_i (dram_awaddr_i)
      ,.dram_ar_v_i   (dram_ar_v_i)
      ,.dram_araddr_i (dram_araddr_i)
      ,.m_aw_v_o      (m_aw_v_o)
      ,.m_awaddr_o    (m_awaddr_o)
      ,.m_ar_v_o      (m_ar_v_o)
      ,.m_araddr_o    (m_araddr_o)
      );

   always #20 aclk = ~aclk;

   always @(posedge aclk) begin
      if (rst_i) begin
         cyc <= '0;
      end
      else begin
         cyc <= cyc + 1;
      end
   end

   // processor base comes off by xor, then the host base is added
   function automatic paddr_t expected_xlate(paddr_t addr, paddr_t base);
      return (addr ^ 32'h8000_0000) + base;
   endfunction

   // one bit per 8 MB region, taken from processor address bits 29:23
   function automatic profile_t mark_region(profile_t map, paddr_t addr);
      profile_t hit;
      hit = '0;
      hit[addr[29:23]] = 1'b1;
      return map | hit;
   endfunction

   // any address inside the 256 MB window
   function automatic paddr_t random_dram_addr();
      return 32'h8000_0000 | ($urandom & 32'h0fff_ffff);
   endfunction

   task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic end_run();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end
      else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   task automatic give_up(string what);
      $display("timeout at %0t: %s", $time, what);
      errors++;
      end_run();
   endtask

   task automatic start_test(string name);
      test_name = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: passed", test_name);
      end
      else begin
         $display("test %s: failed with %0d errors", test_name, test_errors);
         tests_failed++;
      end
   endtask

   task automatic write_word(csr_addr_t addr, csr_data_t data);
      @(negedge aclk);
      csr_we_i = 1'b1;
      csr_waddr_i = addr;
      csr_wdata_i = data;
      @(negedge aclk);
      csr_we_i = 1'b0;
   endtask

   // read data must arrive on the very next cycle
   task automatic expect_word(csr_addr_t addr, csr_data_t exp);
      int waited;
      @(negedge aclk);
      // the previous read valid is a single cycle pulse
      check_value($sformatf("csr_rvalid_o before read of word %0d", addr),
                  32'(csr_rvalid_o), 32'd0);
      csr_re_i = 1'b1;
      csr_raddr_i = addr;
      @(negedge aclk);
      csr_re_i = 1'b0;
      waited = 0;
      while (!csr_rvalid_o && waited < timeout_cycles) begin
         @(negedge aclk);
         waited++;
      end
      if (!csr_rvalid_o) begin
         give_up($sformatf("read of word %0d never returned", addr));
      end
      else begin
         check_value($sformatf("read latency of word %0d", addr), waited, 0);
         check_value($sformatf("word %0d", addr), csr_rdata_o, exp);
      end
   endtask

   task automatic drive_strobes(logic aw_v, logic ar_v);
      paddr_t aw_addr;
      paddr_t ar_addr;
      aw_addr = random_dram_addr();
      ar_addr = random_dram_addr();
      @(negedge aclk);
      dram_aw_v_i = aw_v;
      dram_awaddr_i = aw_addr;
      dram_ar_v_i = ar_v;
      dram_araddr_i = ar_addr;
      if (aw_v) begin
         aw_exp_q.push_back(expected_xlate(aw_addr, dram_base));
         aw_due_q.push_back(cyc + 1);
         ref_profile = mark_region(ref_profile, aw_addr);
      end
      if (ar_v) begin
         ar_exp_q.push_back(expected_xlate(ar_addr, dram_base));
         ar_due_q.push_back(cyc + 1);
         ref_profile = mark_region(ref_profile, ar_addr);
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while ((aw_exp_q.size() != 0 || ar_exp_q.size() != 0) && waited < timeout_cycles) begin
         @(posedge aclk);
         waited++;
      end
      if (aw_exp_q.size() != 0 || ar_exp_q.size() != 0) begin
         give_up("a translator never produced an expected strobe");
      end
   endtask

   // back to back strobes, optionally with random idle cycles between them
   task automatic run_burst(int count, logic aw_on, logic ar_on, logic gaps);
      for (int i = 0; i < count; i++) begin
         drive_strobes(aw_on, ar_on);
         if (gaps && (($urandom % 3) == 0)) begin
            drive_strobes(1'b0, 1'b0);
         end
      end
      drive_strobes(1'b0, 1'b0);
      wait_drained();
   endtask

   // translator outputs are registered, so they are stable at the falling edge
   always @(negedge aclk) begin
      if (m_aw_v_o) begin
         if (aw_exp_q.size() == 0) begin
            $display("error at %0t: write strobe with no address outstanding", $time);
            errors++;
            test_errors++;
         end
         else begin
            check_value("write channel due cycle", cyc, aw_due_q.pop_front());
            check_value("write channel address", m_awaddr_o, aw_exp_q.pop_front());
         end
      end
      if (m_ar_v_o) begin
         if (ar_exp_q.size() == 0) begin
            $display("error at %0t: read strobe with no address outstanding", $time);
            errors++;
            test_errors++;
         end
         else begin
            check_value("read channel due cycle", cyc, ar_due_q.pop_front());
            check_value("read channel address", m_araddr_o, ar_exp_q.pop_front());
         end
      end
   end

   initial begin
      csr_data_t vals [3];
      csr_addr_t idx;
      seed_dummy = $urandom(32'hdcee5e7c);
      aclk = 1'b0;
      rst_i = 1'b1;
      csr_we_i = 1'b0;
      csr_waddr_i = '0;
      csr_wdata_i = '0;
      csr_re_i = 1'b0;
      csr_raddr_i = '0;
      dram_aw_v_i = 1'b0;
      dram_awaddr_i = '0;
      dram_ar_v_i = 1'b0;
      dram_araddr_i = '0;
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      dram_base = '0;
      ref_profile = '0;
      repeat (10) @(negedge aclk);
      rst_i = 1'b0;

      start_test("after reset");
      check_value("bp_reset_o", 32'(bp_reset_o), 32'd1);
      check_value("m_aw_v_o", 32'(m_aw_v_o), 32'd0);
      check_value("m_ar_v_o", 32'(m_ar_v_o), 32'd0);
      check_value("csr_rvalid_o", 32'(csr_rvalid_o), 32'd0);
      for (int w = 0; w < 7; w++) begin
         expect_word(csr_addr_t'(w), '0);
      end
      finish_test();

      start_test("register readback");
      for (int r = 0; r < 4; r++) begin
         for (int w = 0; w < 3; w++) begin
            vals[w] = $urandom;
            write_word(csr_addr_t'(w), vals[w]);
         end
         for (int w = 0; w < 3; w++) begin
            expect_word(csr_addr_t'(w), vals[w]);
         end
         check_value("bp_reset_o", 32'(bp_reset_o), 32'(!vals[0][0]));
      end
      write_word(csr_reset_idx_lp, 32'd1);
      check_value("bp_reset_o out of reset", 32'(bp_reset_o), 32'd0);
      write_word(csr_reset_idx_lp, 32'd0);
      check_value("bp_reset_o back in reset", 32'(bp_reset_o), 32'd1);
      // the profiler words are not writable and word 7 is unmapped
      write_word(csr_profile_idx_lp, $urandom);
      expect_word(csr_profile_idx_lp, '0);
      expect_word(3'd7, '0);
      finish_test();

      start_test("write channel translation");
      dram_base = $urandom;
      write_word(csr_dram_base_idx_lp, dram_base);
      run_burst(16, 1'b1, 1'b0, 1'b0);
      run_burst(16, 1'b1, 1'b0, 1'b1);
      finish_test();

      start_test("read channel translation");
      dram_base = $urandom;
      write_word(csr_dram_base_idx_lp, dram_base);
      run_burst(16, 1'b0, 1'b1, 1'b0);
      run_burst(24, 1'b1, 1'b1, 1'b1);
      finish_test();

      start_test("profiler accumulation");
      write_word(csr_reset_idx_lp, 32'd1);
      check_value("bp_reset_o", 32'(bp_reset_o), 32'd0);
      ref_profile = '0;
      run_burst(40, 1'b1, 1'b1, 1'b1);
      for (int w = 0; w < 4; w++) begin
         idx = csr_addr_t'(csr_profile_idx_lp + w);
         expect_word(idx, ref_profile[w*32 +: 32]);
      end
      finish_test();

      start_test("profiler clear");
      write_word(csr_reset_idx_lp, 32'd0);
      check_value("bp_reset_o", 32'(bp_reset_o), 32'd1);
      ref_profile = '0;
      for (int w = 0; w < 4; w++) begin
         idx = csr_addr_t'(csr_profile_idx_lp + w);
         expect_word(idx, ref_profile[w*32 +: 32]);
      end
      finish_test();

      end_run();
   end

endmodule

`default_nettype wire

// File: all.f
common/zynq_glue_pkg.sv
dram/dram_addr_xlate.sv
dram/mem_profiler.sv
verilog/host_csr_regs.sv
verilog/zynq_dram_glue.sv
sim/tb_zynq_dram_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log

set -u

top=tb_zynq_dram_glue
build_dir=obj_dir
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -Wno-fatal \
   -f all.f \
   --top-module "$top" \
   -Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $log"
   exit 1
fi
